//--- src/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath and register file geometry.
`define XLEN        64
`define REG_ADDR_W  5
`define REG_COUNT   32
`define REGS_INIT   64'h0

// Major opcodes of the supported instruction groups.
`define OPC_OP        7'b0110011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_32     7'b0111011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_LUI       7'b0110111

// funct3 and funct7 encodings of the integer group.
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

// ALU operation codes.
`define ALU_OP_W    4
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9
`define ALU_PASS_B  4'd10

`endif

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Register-register layout.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Immediate layout, also used by the immediate shifts.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Upper immediate layout for LUI.
  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One instruction word seen through all three layouts.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } instr_u;

endpackage

`default_nettype wire

//--- src/reg_read_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

interface reg_read_if;
  logic                   rd1_en;
  logic                   rd2_en;
  logic [`REG_ADDR_W-1:0] rd1_addr;
  logic [`REG_ADDR_W-1:0] rd2_addr;
  logic [`XLEN-1:0]       rd1_data;
  logic [`XLEN-1:0]       rd2_data;

  modport requester (
    output rd1_en, rd2_en, rd1_addr, rd2_addr,
    input  rd1_data, rd2_data
  );

  modport responder (
    input  rd1_en, rd2_en, rd1_addr, rd2_addr,
    output rd1_data, rd2_data
  );
endinterface

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module reg_file (
  input  wire logic                   clk,
  input  wire logic                   rst,
  reg_read_if.responder               rd,
  input  wire logic                   wr_en,
  input  wire logic [`REG_ADDR_W-1:0] wr_addr,
  input  wire logic [`XLEN-1:0]       wr_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic             wr_commit;

  assign wr_commit = wr_en && (wr_addr != '0); // x0 never takes a write.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= `REGS_INIT;
      end
    end else if (wr_commit) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Reads are combinational, so a write lands before the next instruction reads it.
  assign rd.rd1_data = rd.rd1_en ? regs[rd.rd1_addr] : `REGS_INIT;
  assign rd.rd2_data = rd.rd2_en ? regs[rd.rd2_addr] : `REGS_INIT;

endmodule

`default_nettype wire

//--- src/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module instr_decoder (
  input  wire rv_pkg::instr_u          instr,
  reg_read_if.requester                rd,
  output logic [`ALU_OP_W-1:0]         alu_op,
  output logic                         use_imm,
  output logic                         word_op,
  output logic [`XLEN-1:0]             imm,
  output logic [`REG_ADDR_W-1:0]       rd_addr,
  output logic                         rd_we,
  output logic                         illegal
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             f7_base;
  logic             f7_alt;
  logic             sh_base;
  logic             sh_alt;
  logic             is_shr;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic             bad;

  // The alt bit picks SUB or SRA in the shared funct3 map.
  function automatic logic [`ALU_OP_W-1:0] f3_to_op(input logic [2:0] f3, input logic alt);
    logic [`ALU_OP_W-1:0] op;
    case (f3)
      `F3_ADD_SUB: op = alt ? `ALU_SUB : `ALU_ADD;
      `F3_SLL:     op = `ALU_SLL;
      `F3_SLT:     op = `ALU_SLT;
      `F3_SLTU:    op = `ALU_SLTU;
      `F3_XOR:     op = `ALU_XOR;
      `F3_SRL_SRA: op = alt ? `ALU_SRA : `ALU_SRL;
      `F3_OR:      op = `ALU_OR;
      default:     op = `ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode  = instr.r.opcode;
  assign funct3  = instr.r.funct3;
  assign funct7  = instr.r.funct7;
  assign f7_base = (funct7 == `F7_BASE);
  assign f7_alt  = (funct7 == `F7_ALT);
  // RV64 immediate shifts use bit 25 as shamt[5].
  assign sh_base = (funct7[6:1] == `F7_BASE >> 1);
  assign sh_alt  = (funct7[6:1] == `F7_ALT >> 1);
  assign is_shr  = (funct3 == `F3_SRL_SRA);

  assign imm_i = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_u = {{(`XLEN-32){instr.u.imm20[19]}}, instr.u.imm20, 12'b0};

  assign rd.rd1_addr = instr.r.rs1;
  assign rd.rd2_addr = instr.r.rs2;
  assign rd_addr     = instr.r.rd;

  always_comb begin
    rd.rd1_en = 1'b0;
    rd.rd2_en = 1'b0;
    alu_op    = `ALU_ADD;
    use_imm   = 1'b0;
    word_op   = 1'b0;
    imm       = imm_i;
    rd_we     = 1'b0;
    bad       = 1'b0;
    case (opcode)
      `OPC_OP: begin
        rd.rd1_en = 1'b1;
        rd.rd2_en = 1'b1;
        rd_we     = 1'b1;
        alu_op    = f3_to_op(funct3, f7_alt);
        if (funct3 == `F3_ADD_SUB || is_shr) begin
          bad = !(f7_base || f7_alt);
        end else begin
          bad = !f7_base;
        end
      end
      `OPC_OP_IMM: begin
        rd.rd1_en = 1'b1;
        use_imm   = 1'b1;
        rd_we     = 1'b1;
        alu_op    = f3_to_op(funct3, sh_alt && is_shr);
        if (funct3 == `F3_SLL) begin
          bad = !sh_base;
        end else if (is_shr) begin
          bad = !(sh_base || sh_alt);
        end
      end
      `OPC_OP_32: begin
        rd.rd1_en = 1'b1;
        rd.rd2_en = 1'b1;
        word_op   = 1'b1;
        rd_we     = 1'b1;
        alu_op    = f3_to_op(funct3, f7_alt);
        case (funct3)
          `F3_ADD_SUB, `F3_SRL_SRA: bad = !(f7_base || f7_alt);
          `F3_SLL:                  bad = !f7_base;
          default:                  bad = 1'b1;
        endcase
      end
      `OPC_OP_IMM_32: begin
        rd.rd1_en = 1'b1;
        use_imm   = 1'b1;
        word_op   = 1'b1;
        rd_we     = 1'b1;
        alu_op    = f3_to_op(funct3, f7_alt && is_shr);
        case (funct3)
          `F3_ADD_SUB: bad = 1'b0; // ADDIW has no funct7.
          `F3_SLL:     bad = !f7_base;
          `F3_SRL_SRA: bad = !(f7_base || f7_alt);
          default:     bad = 1'b1;
        endcase
      end
      `OPC_LUI: begin
        use_imm = 1'b1;
        imm     = imm_u;
        alu_op  = `ALU_PASS_B;
        rd_we   = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      rd_we = 1'b0;
    end
  end

  assign illegal = bad;

endmodule

`default_nettype wire

//--- src/int_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module int_alu (
  input  wire logic [`ALU_OP_W-1:0] alu_op,
  input  wire logic                 word_op,
  input  wire logic [`XLEN-1:0]     a,
  input  wire logic [`XLEN-1:0]     b,
  output logic [`XLEN-1:0]          y
);

  logic [5:0]       shamt;
  logic [`XLEN-1:0] full_y;
  logic [31:0]      a_lo;
  logic [31:0]      word_y;

  assign shamt = b[5:0];
  assign a_lo  = a[31:0];

  always_comb begin
    case (alu_op)
      `ALU_ADD:    full_y = a + b;
      `ALU_SUB:    full_y = a - b;
      `ALU_SLL:    full_y = a << shamt;
      `ALU_SLT:    full_y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      `ALU_SLTU:   full_y = {{(`XLEN-1){1'b0}}, a < b};
      `ALU_XOR:    full_y = a ^ b;
      `ALU_SRL:    full_y = a >> shamt;
      `ALU_SRA:    full_y = $signed(a) >>> shamt;
      `ALU_OR:     full_y = a | b;
      `ALU_AND:    full_y = a & b;
      `ALU_PASS_B: full_y = b;
      default:     full_y = '0;
    endcase
  end

  // Word shifts see only the low word and five shift bits.
  always_comb begin
    case (alu_op)
      `ALU_SLL: word_y = a_lo << shamt[4:0];
      `ALU_SRL: word_y = a_lo >> shamt[4:0];
      `ALU_SRA: word_y = $signed(a_lo) >>> shamt[4:0];
      default:  word_y = full_y[31:0]; // Add and sub agree in the low word.
    endcase
  end

  assign y = word_op ? {{(`XLEN-32){word_y[31]}}, word_y} : full_y;

endmodule

`default_nettype wire

//--- src/exec_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module exec_core (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   instr_valid,
  input  wire logic [31:0]            instr,
  output logic                        retire_valid,
  output logic [`REG_ADDR_W-1:0]      retire_rd,
  output logic [`XLEN-1:0]            retire_data,
  output logic                        retire_illegal
);

  rv_pkg::instr_u         instr_word;
  logic [`ALU_OP_W-1:0]   alu_op;
  logic                   use_imm;
  logic                   word_op;
  logic [`XLEN-1:0]       imm;
  logic [`REG_ADDR_W-1:0] rd_addr;
  logic                   rd_we;
  logic                   illegal;
  logic [`XLEN-1:0]       opnd_b;
  logic [`XLEN-1:0]       alu_y;
  logic                   wr_en;

  reg_read_if rd_bus ();

  assign instr_word = instr;

  instr_decoder i_decoder (
    .instr   (instr_word),
    .rd      (rd_bus.requester),
    .alu_op  (alu_op),
    .use_imm (use_imm),
    .word_op (word_op),
    .imm     (imm),
    .rd_addr (rd_addr),
    .rd_we   (rd_we),
    .illegal (illegal)
  );

  assign opnd_b = use_imm ? imm : rd_bus.rd2_data;

  int_alu i_alu (
    .alu_op  (alu_op),
    .word_op (word_op),
    .a       (rd_bus.rd1_data),
    .b       (opnd_b),
    .y       (alu_y)
  );

  assign wr_en = instr_valid && rd_we; // Illegal words never reach the register file.

  reg_file i_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rd      (rd_bus.responder),
    .wr_en   (wr_en),
    .wr_addr (rd_addr),
    .wr_data (alu_y)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid   <= 1'b0;
      retire_illegal <= 1'b0;
    end else begin
      retire_valid   <= instr_valid;
      retire_illegal <= instr_valid && illegal;
    end
  end

  // Retire payload follows the same edge as the register write.
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      retire_rd   <= rd_addr;
      retire_data <= illegal ? `REGS_INIT : alu_y;
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_exec_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module tb_exec_core;

  typedef struct packed {
    logic [4:0]  rd;
    logic [63:0] value;
    logic        we;
    logic        ill;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic [63:0] retire_data;
  logic        retire_illegal;

  logic [63:0] shadow [32];
  expect_t     pending [$];
  logic        retire_due;
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_start_errors;

  exec_core i_dut (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .retire_illegal (retire_illegal)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm12, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm12, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] encode_lui(input logic [19:0] imm20, input logic [4:0] rd);
    return {imm20, rd, `OPC_LUI};
  endfunction

  function automatic logic [63:0] sign_ext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // Full-width integer operation as the ISA defines it for funct3.
  function automatic logic [63:0] int_op64(input logic [2:0] f3, input logic alt,
      input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'b0, $signed(a) < $signed(b)};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[5:0];
        end else begin
          r = a >> b[5:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // A word operation sign-extends its low word result from bit 31.
  function automatic logic [63:0] int_op32(input logic [2:0] f3, input logic alt,
      input logic [63:0] a, input logic [63:0] b);
    logic [31:0]        lo;
    logic signed [63:0] a_sx;
    logic [63:0]        sr;
    a_sx = sign_ext32(a[31:0]);
    sr = a_sx >>> b[4:0];
    case (f3)
      3'd0: lo = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      3'd1: lo = a[31:0] << b[4:0];
      default: lo = alt ? sr[31:0] : a[31:0] >> b[4:0];
    endcase
    return sign_ext32(lo);
  endfunction

  function automatic expect_t expected_retire(input logic [31:0] w, input logic [63:0] a,
      input logic [63:0] rb);
    expect_t     e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] imm;
    logic        ok;
    logic [63:0] r;
    f3 = w[14:12];
    f7 = w[31:25];
    imm = {{52{w[31]}}, w[31:20]};
    ok = 1'b0;
    r = 64'h0;
    case (w[6:0])
      `OPC_OP: begin
        ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        r = int_op64(f3, f7[5], a, rb);
      end
      `OPC_OP_IMM: begin
        if (f3 == 3'd1) ok = (w[31:26] == 6'h00);
        else if (f3 == 3'd5) ok = (w[31:26] == 6'h00) || (w[31:26] == 6'h10);
        else ok = 1'b1;
        r = int_op64(f3, (f3 == 3'd5) && w[30], a, imm);
      end
      `OPC_OP_32: begin
        if (f3 == 3'd0 || f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
        else if (f3 == 3'd1) ok = (f7 == 7'h00);
        r = int_op32(f3, f7[5], a, rb);
      end
      `OPC_OP_IMM_32: begin
        if (f3 == 3'd0) ok = 1'b1;
        else if (f3 == 3'd1) ok = (f7 == 7'h00);
        else if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
        r = int_op32(f3, (f3 == 3'd5) && f7[5], a, imm);
      end
      `OPC_LUI: begin
        ok = 1'b1;
        r = {{32{w[31]}}, w[31:12], 12'h000};
      end
      default: ok = 1'b0;
    endcase
    e.rd = w[11:7];
    e.we = ok;
    e.ill = !ok;
    e.value = ok ? r : 64'h0;
    return e;
  endfunction

  task automatic issue(input logic [31:0] w);
    expect_t e;
    e = expected_retire(w, shadow[w[19:15]], shadow[w[24:20]]);
    pending.push_back(e);
    if (e.we && e.rd != 5'd0) shadow[e.rd] = e.value;
    @(posedge clk);
    instr_valid <= 1'b1;
    instr <= w;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk);
    instr_valid <= 1'b0;
    while (pending.size() != 0 && waited < 50) begin
      @(posedge clk);
      waited++;
    end
    if (pending.size() != 0) begin
      $display("ERROR: %0d retires did not arrive within 50 cycles", pending.size());
      errors++;
      pending.delete();
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // An instruction sampled at this edge must retire right after it.
  always @(posedge clk) begin
    retire_due <= !rst && instr_valid;
  end

  // Retire outputs are stable at the falling edge.
  always @(negedge clk) begin
    expect_t e;
    if (!rst) begin
      if (retire_valid !== retire_due) begin
        $display("FAILED retire_valid expected %h got %h", retire_due, retire_valid);
        errors++;
      end
      if (retire_valid === 1'b1) begin
        if (pending.size() == 0) begin
          $display("ERROR: retire_valid was high with no instruction outstanding");
          errors++;
        end else begin
          e = pending.pop_front();
          checks++;
          if (retire_rd !== e.rd) begin
            $display("FAILED retire_rd expected %h got %h", e.rd, retire_rd);
            errors++;
          end
          if (retire_data !== e.value) begin
            $display("FAILED retire_data expected %h got %h", e.value, retire_data);
            errors++;
          end
          if (retire_illegal !== e.ill) begin
            $display("FAILED retire_illegal expected %h got %h", e.ill, retire_illegal);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [4:0]  last_rd;
    logic [2:0]  f3;
    logic        alt;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [11:0] imm12;
    clk = 1'b0;
    rst = 1'b1;
    instr_valid = 1'b0;
    instr = 32'h0;
    rng_state = 32'h147;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    test_start_errors = 0;
    last_rd = 5'd0;
    for (int i = 0; i < 32; i++) shadow[i] = 64'h0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    if (retire_valid !== 1'b0) begin
      $display("FAILED retire_valid expected %h got %h", 1'b0, retire_valid);
      errors++;
    end
    if (retire_illegal !== 1'b0) begin
      $display("FAILED retire_illegal expected %h got %h", 1'b0, retire_illegal);
      errors++;
    end
    for (int i = 0; i < 32; i++) issue(encode_r(7'h00, i[4:0], 5'd0, 3'd0, i[4:0], `OPC_OP));
    drain();
    end_test("reset state");

    issue(encode_i(12'hfff, 5'd0, 3'd0, 5'd1, `OPC_OP_IMM)); // All ones.
    issue(encode_i(12'h800, 5'd0, 3'd0, 5'd2, `OPC_OP_IMM)); // Most negative immediate.
    for (int i = 1; i < 32; i++) begin
      r = next_random();
      issue(encode_lui(r[19:0], i[4:0]));
      issue(encode_i(r[31:20], i[4:0], 3'd0, i[4:0], `OPC_OP_IMM));
    end
    drain();
    end_test("immediates and lui");

    for (int n = 0; n < 200; n++) begin
      r = next_random();
      f3 = r[2:0];
      alt = r[3] && (f3 == 3'd0 || f3 == 3'd5);
      issue(encode_r(alt ? 7'h20 : 7'h00, r[19:15], r[9] ? last_rd : r[14:10], f3, r[8:4],
                     `OPC_OP));
      last_rd = r[8:4];
    end
    drain();
    end_test("register ops");

    issue(encode_lui(20'h80000, 5'd5));
    issue(encode_i(12'h7f0, 5'd5, 3'd0, 5'd5, `OPC_OP_IMM)); // Negative low word.
    issue(encode_i({7'h20, 5'd4}, 5'd5, 3'd5, 5'd6, `OPC_OP_IMM_32)); // sraiw
    issue(encode_i({7'h00, 5'd4}, 5'd5, 3'd5, 5'd7, `OPC_OP_IMM_32)); // srliw
    issue(encode_i(12'd7, 5'd0, 3'd0, 5'd8, `OPC_OP_IMM));
    issue(encode_r(7'h20, 5'd8, 5'd5, 3'd5, 5'd9, `OPC_OP_32)); // sraw
    issue(encode_r(7'h00, 5'd8, 5'd5, 3'd5, 5'd10, `OPC_OP_32)); // srlw
    for (int n = 0; n < 150; n++) begin
      r = next_random();
      f3 = (r[2:1] == 2'd0) ? 3'd0 : (r[2:1] == 2'd1) ? 3'd1 : 3'd5;
      alt = r[3] && (f3 != 3'd1);
      if (r[0]) begin
        issue(encode_r(alt ? 7'h20 : 7'h00, r[19:15], r[14:10], f3, r[8:4], `OPC_OP_32));
      end else begin
        imm12 = (f3 == 3'd0) ? r[31:20] : {(alt ? 7'h20 : 7'h00), r[24:20]};
        issue(encode_i(imm12, r[14:10], f3, r[8:4], `OPC_OP_IMM_32));
      end
    end
    drain();
    end_test("word forms");

    issue(encode_i(12'd123, 5'd1, 3'd0, 5'd0, `OPC_OP_IMM));
    issue(encode_lui(20'habcde, 5'd0));
    issue(encode_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd0, `OPC_OP));
    issue(encode_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd12, `OPC_OP));
    issue(encode_i(12'd0, 5'd0, 3'd0, 5'd13, `OPC_OP_IMM));
    issue(encode_r(7'h00, 5'd5, 5'd0, 3'd6, 5'd14, `OPC_OP));
    drain();
    end_test("x0 stays zero");

    for (int n = 0; n < 60; n++) begin
      r = next_random();
      r2 = next_random();
      if (r[0]) begin
        opc = r[7:1];
        if (opc == `OPC_OP || opc == `OPC_OP_IMM || opc == `OPC_OP_32 ||
            opc == `OPC_OP_IMM_32 || opc == `OPC_LUI) opc = 7'h7f;
        issue({r2[31:7], opc});
      end else begin
        f7 = r[14:8];
        if (f7 == 7'h00 || f7 == 7'h20) f7 = 7'h01;
        issue(encode_r(f7, r[19:15], r[24:20], r2[2:0], r2[7:3], `OPC_OP));
      end
    end
    for (int i = 0; i < 32; i++) issue(encode_r(7'h00, 5'd0, i[4:0], 3'd0, i[4:0], `OPC_OP));
    drain();
    end_test("illegal words");

    $display("tests run %0d, tests failed %0d, retires checked %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/rv_pkg.sv
src/reg_read_if.sv
src/reg_file.sv
src/instr_decoder.sv
src/int_alu.sv
src/exec_core.sv
verif/tb_exec_core.sv

//--- Makefile
# Verilator simulation of the execute core testbench.

VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
